// File: design/bp_uncore_msg_pkg.sv
// uncore message format shared by memory and host
// widths, type and size encodings, command/response struct
package bp_uncore_msg_pkg;

  // physical address width
  localparam int paddr_width_gp = 32;

  // data path is one dword
  localparam int dword_width_gp = 64;

  // bytes per dword and the offset bits that pick one
  localparam int dword_bytes_gp = dword_width_gp / 8;
  localparam int byte_offset_width_gp = $clog2(dword_bytes_gp);

  // command or response kind
  typedef enum logic [0:0]
  {
    e_mem_rd = 1'b0
    , e_mem_wr = 1'b1
  } msg_type_e;

  // access size, log2 of the byte count
  typedef enum logic [1:0]
  {
    e_size_1 = 2'b00
    , e_size_2 = 2'b01
    , e_size_4 = 2'b10
    , e_size_8 = 2'b11
  } msg_size_e;

  // one message, 99 bits
  // responses echo type, size and addr
  // read data zero-extended from the low bytes, zero on writes
  typedef struct packed
  {
    msg_type_e msg_type;
    msg_size_e size;
    logic [paddr_width_gp-1:0] addr;
    logic [dword_width_gp-1:0] data;
  } mem_msg_s;

endpackage

// File: design/bp_host_map_pkg.sv
// host device address map
// putchar and finish addresses, finish-bit sizing
package bp_host_map_pkg;

  // write here emits the low data byte
  localparam logic [31:0] putchar_addr_gp = 32'h0010_1000;

  // finish window base, one dword slot per core
  // core n finishes with a write at base + 8*n
  localparam logic [31:0] finish_base_addr_gp = 32'h0010_2000;

  // upper bound on cores the finish window covers
  localparam int max_cores_gp = 16;

  // bits of the core index inside the finish window
  localparam int finish_core_width_gp = $clog2(max_cores_gp);

endpackage

// File: design/bp_mem_latency.sv
// fixed-latency response pipeline
// valid-tagged shift stages into a circular queue, credit back-pressure
`timescale 1ns/1ps

module bp_mem_latency
  #(parameter int latency_p = 4
    , parameter int queue_els_p = 4
    )
  (input clk_i
   , input reset_i

   , input bp_uncore_msg_pkg::mem_msg_s enq_msg_i
   , input enq_v_i
   , output logic enq_ready_o

   , output bp_uncore_msg_pkg::mem_msg_s deq_msg_o
   , output logic deq_v_o
   , input deq_yumi_i
   );

  localparam int ptr_width_lp = (queue_els_p > 1) ? $clog2(queue_els_p) : 1;
  localparam int cnt_width_lp = $clog2(queue_els_p + 1);

  // shift stages
  logic [latency_p-1:0] stage_v_r;
  bp_uncore_msg_pkg::mem_msg_s stage_msg_r [latency_p];

  // output queue storage and state
  bp_uncore_msg_pkg::mem_msg_s queue_mem_r [queue_els_p];
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] queue_cnt_r;

  // in flight plus queued
  logic [cnt_width_lp-1:0] credit_r;

  logic enq_li;
  logic push_li;
  logic pop_li;

  // full credits hold off new commands
  assign enq_ready_o = (credit_r != cnt_width_lp'(queue_els_p));
  assign enq_li = enq_v_i & enq_ready_o;

  // last stage always has room in the queue
  assign push_li = stage_v_r[latency_p-1];

  assign deq_v_o = (queue_cnt_r != '0);
  assign deq_msg_o = queue_mem_r[rd_ptr_r];
  assign pop_li = deq_yumi_i & deq_v_o;

  // valid tags shift every cycle
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      stage_v_r <= '0;
    else
    begin
      stage_v_r[0] <= enq_li;
      for (int i = 1; i < latency_p; i++)
        stage_v_r[i] <= stage_v_r[i-1];
    end
  end

  // payload follows its tag
  always_ff @(posedge clk_i)
  begin
    stage_msg_r[0] <= enq_msg_i;
    for (int i = 1; i < latency_p; i++)
      stage_msg_r[i] <= stage_msg_r[i-1];
  end

  // queue write port
  always_ff @(posedge clk_i)
  begin
    if (push_li)
      queue_mem_r[wr_ptr_r] <= stage_msg_r[latency_p-1];
  end

  // pointers wrap at queue_els_p
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end
    else
    begin
      if (push_li)
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(queue_els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop_li)
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(queue_els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
    end
  end

  // occupancy counters
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      queue_cnt_r <= '0;
      credit_r <= '0;
    end
    else
    begin
      case ({push_li, pop_li})
        2'b10: queue_cnt_r <= queue_cnt_r + 1'b1;
        2'b01: queue_cnt_r <= queue_cnt_r - 1'b1;
        default: queue_cnt_r <= queue_cnt_r;
      endcase
      // a credit returns only when the response leaves
      case ({enq_li, pop_li})
        2'b10: credit_r <= credit_r + 1'b1;
        2'b01: credit_r <= credit_r - 1'b1;
        default: credit_r <= credit_r;
      endcase
    end
  end

endmodule

// File: design/bp_mem.sv
// byte-addressed dword memory with sized read and write
// responses go through the fixed-latency pipeline
`timescale 1ns/1ps

module bp_mem
  #(parameter int mem_els_p = 1024
    , parameter int latency_p = 4
    , parameter int queue_els_p = 4
    )
  (input clk_i
   , input reset_i

   , input bp_uncore_msg_pkg::mem_msg_s mem_cmd_i
   , input mem_cmd_v_i
   , output logic mem_cmd_ready_o

   , output bp_uncore_msg_pkg::mem_msg_s mem_resp_o
   , output logic mem_resp_v_o
   , input mem_resp_yumi_i
   );

  localparam int data_width_lp = bp_uncore_msg_pkg::dword_width_gp;
  localparam int bytes_lp = bp_uncore_msg_pkg::dword_bytes_gp;
  localparam int off_width_lp = bp_uncore_msg_pkg::byte_offset_width_gp;
  localparam int idx_width_lp = (mem_els_p > 1) ? $clog2(mem_els_p) : 1;

  // storage, zero at start
  logic [data_width_lp-1:0] mem_r [mem_els_p] = '{default: '0};

  logic [idx_width_lp-1:0] idx_li;
  logic [off_width_lp-1:0] off_li;
  logic [bytes_lp-1:0] size_be_li;
  logic [bytes_lp-1:0] wr_be_li;
  logic [data_width_lp-1:0] size_mask_li;
  logic [data_width_lp-1:0] wr_data_li;
  logic [data_width_lp-1:0] rd_data_li;
  logic cmd_accept_li;
  logic is_wr_li;
  logic enq_ready_lo;
  bp_uncore_msg_pkg::mem_msg_s resp_li;

  // dword index above the byte offset
  assign idx_li = mem_cmd_i.addr[off_width_lp +: idx_width_lp];
  assign off_li = mem_cmd_i.addr[off_width_lp-1:0];

  assign is_wr_li = (mem_cmd_i.msg_type == bp_uncore_msg_pkg::e_mem_wr);

  // ready comes straight from the credit counter
  assign mem_cmd_ready_o = enq_ready_lo;
  assign cmd_accept_li = mem_cmd_v_i & enq_ready_lo;

  // low-byte enables for the access size
  always_comb
  begin
    case (mem_cmd_i.size)
      bp_uncore_msg_pkg::e_size_1: size_be_li = bytes_lp'(1);
      bp_uncore_msg_pkg::e_size_2: size_be_li = bytes_lp'(3);
      bp_uncore_msg_pkg::e_size_4: size_be_li = bytes_lp'(15);
      default: size_be_li = '1;
    endcase
  end

  // enables widened to a bit mask
  always_comb
  begin
    for (int b = 0; b < bytes_lp; b++)
      size_mask_li[b*8 +: 8] = {8{size_be_li[b]}};
  end

  // write lanes moved up to the byte offset
  // aligned addresses keep the enables inside the dword
  assign wr_be_li = size_be_li << off_li;
  assign wr_data_li = mem_cmd_i.data << {off_li, 3'b000};

  // read lanes moved down, upper bytes zeroed
  assign rd_data_li = (mem_r[idx_li] >> {off_li, 3'b000}) & size_mask_li;

  // byte-merged write
  always_ff @(posedge clk_i)
  begin
    if (cmd_accept_li & is_wr_li)
    begin
      for (int b = 0; b < bytes_lp; b++)
        if (wr_be_li[b])
          mem_r[idx_li][b*8 +: 8] <= wr_data_li[b*8 +: 8];
    end
  end

  // full response built in the accept cycle
  always_comb
  begin
    resp_li.msg_type = mem_cmd_i.msg_type;
    resp_li.size = mem_cmd_i.size;
    resp_li.addr = mem_cmd_i.addr;
    resp_li.data = is_wr_li ? '0 : rd_data_li;
  end

  bp_mem_latency
    #(.latency_p(latency_p)
      ,.queue_els_p(queue_els_p)
      )
    latency
    (.clk_i(clk_i)
     ,.reset_i(reset_i)

     ,.enq_msg_i(resp_li)
     ,.enq_v_i(cmd_accept_li)
     ,.enq_ready_o(enq_ready_lo)

     ,.deq_msg_o(mem_resp_o)
     ,.deq_v_o(mem_resp_v_o)
     ,.deq_yumi_i(mem_resp_yumi_i)
     );

endmodule

// File: design/bp_nonsynth_host.sv
// host I/O device
// putchar output, sticky per-core finish bits, one held response
`timescale 1ns/1ps

module bp_nonsynth_host
  #(parameter int num_core_p = 1)
  (input clk_i
   , input reset_i

   , input bp_uncore_msg_pkg::mem_msg_s io_cmd_i
   , input io_cmd_v_i
   , output logic io_cmd_ready_o

   , output bp_uncore_msg_pkg::mem_msg_s io_resp_o
   , output logic io_resp_v_o
   , input io_resp_yumi_i

   , output logic [num_core_p-1:0] program_finish_o
   , output logic [7:0] putchar_o
   , output logic putchar_v_o
   );

  localparam int core_width_lp = bp_host_map_pkg::finish_core_width_gp;
  localparam logic [31:0] finish_span_lp = 32'(bp_host_map_pkg::max_cores_gp * 8);

  logic cmd_accept_li;
  logic is_wr_li;
  logic putchar_wr_li;
  logic finish_wr_li;
  logic [31:0] finish_off_li;
  logic [core_width_lp-1:0] finish_core_li;

  // accepted command, acted on one cycle later
  logic cmd_v_r;
  bp_uncore_msg_pkg::mem_msg_s cmd_r;

  logic resp_v_r;
  bp_uncore_msg_pkg::mem_msg_s resp_r;
  logic putchar_v_r;
  logic [7:0] putchar_r;
  logic [num_core_p-1:0] finish_r;

  // one command pending or one response held at most
  assign io_cmd_ready_o = ~(cmd_v_r | resp_v_r);
  assign cmd_accept_li = io_cmd_v_i & io_cmd_ready_o;
  assign is_wr_li = (cmd_r.msg_type == bp_uncore_msg_pkg::e_mem_wr);

  // address decode on the registered command
  assign putchar_wr_li = cmd_v_r & is_wr_li
                         & (cmd_r.addr == bp_host_map_pkg::putchar_addr_gp);

  // finish window, dword slots only
  assign finish_off_li = cmd_r.addr - bp_host_map_pkg::finish_base_addr_gp;
  assign finish_core_li = finish_off_li[3 +: core_width_lp];
  assign finish_wr_li = cmd_v_r & is_wr_li
                        & (cmd_r.addr >= bp_host_map_pkg::finish_base_addr_gp)
                        & (finish_off_li < finish_span_lp)
                        & (finish_off_li[2:0] == 3'b000);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      cmd_v_r <= 1'b0;
      resp_v_r <= 1'b0;
      putchar_v_r <= 1'b0;
      finish_r <= '0;
    end
    else
    begin
      cmd_v_r <= cmd_accept_li;
      // held until yumi
      if (cmd_v_r)
        resp_v_r <= 1'b1;
      else if (io_resp_yumi_i)
        resp_v_r <= 1'b0;
      // single-cycle pulse
      putchar_v_r <= putchar_wr_li;
      // cores past num_core_p fall outside the loop
      for (int c = 0; c < num_core_p; c++)
        if (finish_wr_li & (finish_core_li == core_width_lp'(c)))
          finish_r[c] <= 1'b1;
    end
  end

  // command capture and response payload, data always zero
  always_ff @(posedge clk_i)
  begin
    if (cmd_accept_li)
      cmd_r <= io_cmd_i;
    if (cmd_v_r)
    begin
      resp_r.msg_type <= cmd_r.msg_type;
      resp_r.size <= cmd_r.size;
      resp_r.addr <= cmd_r.addr;
      resp_r.data <= '0;
    end
    if (putchar_wr_li)
      putchar_r <= cmd_r.data[7:0];
  end

  assign io_resp_v_o = resp_v_r;
  assign io_resp_o = resp_r;
  assign putchar_v_o = putchar_v_r;
  assign putchar_o = putchar_r;
  assign program_finish_o = finish_r;

endmodule

// File: design/bp_uncore_top.sv
// uncore top level
// memory and host device behind the core-side command/response ports
`timescale 1ns/1ps

module bp_uncore_top
  #(parameter int num_core_p = 1
    , parameter int mem_els_p = 1024
    , parameter int latency_p = 4
    , parameter int queue_els_p = 4
    )
  (input clk_i
   , input reset_i

   // memory port
   , input bp_uncore_msg_pkg::mem_msg_s mem_cmd_i
   , input mem_cmd_v_i
   , output logic mem_cmd_ready_o

   , output bp_uncore_msg_pkg::mem_msg_s mem_resp_o
   , output logic mem_resp_v_o
   , input mem_resp_yumi_i

   // I/O port
   , input bp_uncore_msg_pkg::mem_msg_s io_cmd_i
   , input io_cmd_v_i
   , output logic io_cmd_ready_o

   , output bp_uncore_msg_pkg::mem_msg_s io_resp_o
   , output logic io_resp_v_o
   , input io_resp_yumi_i

   // host side outputs
   , output logic [num_core_p-1:0] program_finish_o
   , output logic [7:0] putchar_o
   , output logic putchar_v_o
   );

  // memory behind the latency pipeline
  bp_mem
    #(.mem_els_p(mem_els_p)
      ,.latency_p(latency_p)
      ,.queue_els_p(queue_els_p)
      )
    mem
    (.clk_i(clk_i)
     ,.reset_i(reset_i)

     ,.mem_cmd_i(mem_cmd_i)
     ,.mem_cmd_v_i(mem_cmd_v_i)
     ,.mem_cmd_ready_o(mem_cmd_ready_o)

     ,.mem_resp_o(mem_resp_o)
     ,.mem_resp_v_o(mem_resp_v_o)
     ,.mem_resp_yumi_i(mem_resp_yumi_i)
     );

  // host device on the I/O port
  bp_nonsynth_host
    #(.num_core_p(num_core_p))
    host
    (.clk_i(clk_i)
     ,.reset_i(reset_i)

     ,.io_cmd_i(io_cmd_i)
     ,.io_cmd_v_i(io_cmd_v_i)
     ,.io_cmd_ready_o(io_cmd_ready_o)

     ,.io_resp_o(io_resp_o)
     ,.io_resp_v_o(io_resp_v_o)
     ,.io_resp_yumi_i(io_resp_yumi_i)

     ,.program_finish_o(program_finish_o)
     ,.putchar_o(putchar_o)
     ,.putchar_v_o(putchar_v_o)
     );

endmodule

// File: verif/testbench.sv
// testbench for the uncore top level
// pattern-driven memory and I/O traffic, reference models, checks, watchdog
`timescale 1ns/1ps

module testbench;

  localparam int num_core_lp = 2;
  localparam int mem_els_lp = 256;
  localparam int latency_lp = 4;
  localparam int queue_els_lp = 4;
  localparam int reset_cycles_lp = 16;

  typedef bp_uncore_msg_pkg::mem_msg_s msg_s;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  msg_s mem_cmd_i = '0;
  logic mem_cmd_v_i = 1'b0;
  logic mem_cmd_ready_o;
  msg_s mem_resp_o;
  logic mem_resp_v_o;
  logic mem_resp_yumi_i = 1'b0;
  msg_s io_cmd_i = '0;
  logic io_cmd_v_i = 1'b0;
  logic io_cmd_ready_o;
  msg_s io_resp_o;
  logic io_resp_v_o;
  logic io_resp_yumi_i = 1'b0;
  logic [num_core_lp-1:0] program_finish_o;
  logic [7:0] putchar_o;
  logic putchar_v_o;

  // patterns as loaded
  string pat_name [$];
  string pat_port [$];
  msg_s pat_msg [$];
  logic [63:0] pat_exp [$];
  bit load_done = 1'b0;

  // reference memory, dwords
  logic [63:0] model_mem [mem_els_lp];

  // expected responses per port, oldest first
  msg_s mem_exp_q [$];
  int mem_edge_q [$];
  string mem_name_q [$];
  msg_s io_exp_q [$];
  int io_edge_q [$];
  string io_name_q [$];
  logic [7:0] put_q [$];
  int put_edge_q [$];
  string put_name_q [$];

  logic [num_core_lp-1:0] exp_finish = '0;
  logic [num_core_lp-1:0] fin_bits = '0;
  bit fin_pending = 1'b0;
  int fin_edge = 0;

  int cycle_cnt = 0;
  int error_cnt = 0;
  int check_cnt = 0;
  bit press_mode = 1'b0;
  bit stall_seen = 1'b0;
  bit ready_low_seen = 1'b0;
  int max_inflight = 0;
  int mem_hold = 0;
  bit mem_yumi_sent = 1'b0;
  bit io_yumi_sent = 1'b0;

  bp_uncore_top
    #(.num_core_p(num_core_lp)
      ,.mem_els_p(mem_els_lp)
      ,.latency_p(latency_lp)
      ,.queue_els_p(queue_els_lp)
      )
    dut0
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.mem_cmd_i(mem_cmd_i)
     ,.mem_cmd_v_i(mem_cmd_v_i)
     ,.mem_cmd_ready_o(mem_cmd_ready_o)
     ,.mem_resp_o(mem_resp_o)
     ,.mem_resp_v_o(mem_resp_v_o)
     ,.mem_resp_yumi_i(mem_resp_yumi_i)
     ,.io_cmd_i(io_cmd_i)
     ,.io_cmd_v_i(io_cmd_v_i)
     ,.io_cmd_ready_o(io_cmd_ready_o)
     ,.io_resp_o(io_resp_o)
     ,.io_resp_v_o(io_resp_v_o)
     ,.io_resp_yumi_i(io_resp_yumi_i)
     ,.program_finish_o(program_finish_o)
     ,.putchar_o(putchar_o)
     ,.putchar_v_o(putchar_v_o)
     );

  // 100 ns clock
  always #50 clk_i = ~clk_i;

  // edge index, settled by 1 ns after each rising edge
  always @(posedge clk_i)
    cycle_cnt <= cycle_cnt + 1;

  // byte-wise access on the reference memory
  // writes take the low bytes, reads come back zero-extended
  task automatic apply_model(input msg_s cmd, output logic [63:0] rd_data);
    int nbytes;
    int idx;
    int off;
    nbytes = 1 << cmd.size;
    idx = int'((cmd.addr >> 3) % mem_els_lp);
    off = int'(cmd.addr[2:0]);
    rd_data = '0;
    for (int b = 0; b < nbytes; b++)
    begin
      if (cmd.msg_type == bp_uncore_msg_pkg::e_mem_wr)
        model_mem[idx][(off+b)*8 +: 8] = cmd.data[b*8 +: 8];
      else
        rd_data[b*8 +: 8] = model_mem[idx][(off+b)*8 +: 8];
    end
  endtask

  // one line per transaction, '#' lines are comments
  task automatic load_patterns();
    int fd;
    int r;
    int nbytes;
    string line;
    string name;
    string port;
    string op;
    logic [31:0] addr;
    logic [63:0] data;
    logic [63:0] expv;
    msg_s m;
    fd = $fopen("verif/uncore_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the pattern file verif/uncore_patterns.txt");
      error_cnt++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        r = $fgets(line, fd);
        if (line.len() > 2 && line.getc(0) != "#")
        begin
          r = $sscanf(line, "%s %s %s %d %h %h %h", name, port, op, nbytes, addr, data, expv);
          if (r == 7)
          begin
            m.msg_type = (op == "wr") ? bp_uncore_msg_pkg::e_mem_wr : bp_uncore_msg_pkg::e_mem_rd;
            m.size = (nbytes == 1) ? bp_uncore_msg_pkg::e_size_1
                   : (nbytes == 2) ? bp_uncore_msg_pkg::e_size_2
                   : (nbytes == 4) ? bp_uncore_msg_pkg::e_size_4 : bp_uncore_msg_pkg::e_size_8;
            m.addr = addr;
            m.data = data;
            pat_name.push_back(name);
            pat_port.push_back(port);
            pat_msg.push_back(m);
            pat_exp.push_back(expv);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // expectations for one accepted I/O command, accept edge is acc
  task automatic expect_io(input string name, input msg_s cmd, input int acc);
    msg_s e;
    logic [31:0] off;
    e = cmd;
    e.data = '0;
    io_exp_q.push_back(e);
    io_edge_q.push_back(acc + 1);
    io_name_q.push_back(name);
    if (cmd.msg_type == bp_uncore_msg_pkg::e_mem_wr)
    begin
      off = cmd.addr - bp_host_map_pkg::finish_base_addr_gp;
      if (cmd.addr == bp_host_map_pkg::putchar_addr_gp)
      begin
        put_q.push_back(cmd.data[7:0]);
        put_edge_q.push_back(acc + 1);
        put_name_q.push_back(name);
      end
      // slot index past the core count is dropped
      else if (cmd.addr >= bp_host_map_pkg::finish_base_addr_gp && off < 32'd128
               && off[2:0] == 3'b000 && (off >> 3) < num_core_lp)
      begin
        fin_bits = '0;
        fin_bits[off[3 +: 4]] = 1'b1;
        fin_edge = acc + 1;
        fin_pending = 1'b1;
      end
    end
  endtask

  // stimulus
  initial
  begin : drive
    int seed_val;
    logic [63:0] rd;
    msg_s e;
    seed_val = int'($urandom(32'h4417));
    for (int i = 0; i < mem_els_lp; i++)
      model_mem[i] = '0;
    load_patterns();
    load_done = 1'b1;
    repeat (reset_cycles_lp) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    for (int p = 0; p < pat_name.size(); p++)
    begin
      press_mode = (pat_name[p].substr(0, 4) == "press");
      // random idle cycles between commands under back-pressure
      if (press_mode && ($urandom % 3 == 0))
      begin
        mem_cmd_v_i = 1'b0;
        repeat ($urandom % 3 + 1)
        begin
          @(posedge clk_i);
          #1;
        end
      end
      if (pat_port[p] == "mem")
      begin
        mem_cmd_i = pat_msg[p];
        mem_cmd_v_i = 1'b1;
        while (!mem_cmd_ready_o)
        begin
          if (press_mode)
            ready_low_seen = 1'b1;
          @(posedge clk_i);
          #1;
        end
        apply_model(pat_msg[p], rd);
        if (pat_msg[p].msg_type == bp_uncore_msg_pkg::e_mem_rd && rd !== pat_exp[p])
        begin
          $display("[ERROR] %s: pattern file expects %h, model gives %h",
                   pat_name[p], pat_exp[p], rd);
          error_cnt++;
        end
        e = pat_msg[p];
        e.data = rd;
        mem_exp_q.push_back(e);
        mem_edge_q.push_back(cycle_cnt + 1 + latency_lp);
        mem_name_q.push_back(pat_name[p]);
        @(posedge clk_i);
        #1;
        mem_cmd_v_i = 1'b0;
      end
      else
      begin
        io_cmd_i = pat_msg[p];
        io_cmd_v_i = 1'b1;
        while (!io_cmd_ready_o)
        begin
          @(posedge clk_i);
          #1;
        end
        expect_io(pat_name[p], pat_msg[p], cycle_cnt + 1);
        @(posedge clk_i);
        #1;
        io_cmd_v_i = 1'b0;
      end
    end
    press_mode = 1'b0;
    while (mem_exp_q.size() != 0 || io_exp_q.size() != 0 || put_q.size() != 0)
      @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    if (max_inflight < 2)
    begin
      $display("memory never had more than one command in flight");
      error_cnt++;
    end
    if (!ready_low_seen)
    begin
      $display("memory command ready never dropped under back-pressure");
      error_cnt++;
    end
    $display("checks %0d, errors %0d", check_cnt, error_cnt);
    if (error_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // memory responses, first sight of each head is checked
  always @(posedge clk_i)
  begin : mem_watch
    #1;
    if (!reset_i)
    begin
      if (mem_yumi_sent)
      begin
        void'(mem_exp_q.pop_front());
        void'(mem_edge_q.pop_front());
        void'(mem_name_q.pop_front());
        if (mem_exp_q.size() == 0)
          stall_seen = 1'b0;
      end
      if (mem_exp_q.size() > max_inflight)
        max_inflight = mem_exp_q.size();
      if (mem_resp_v_o && (mem_yumi_sent || mem_hold == 0))
      begin
        check_cnt++;
        if (mem_exp_q.size() == 0)
        begin
          $display("memory response arrived with none outstanding");
          error_cnt++;
        end
        else
        begin
          if (mem_resp_o !== mem_exp_q[0])
          begin
            $display("[ERROR] %s: expected %h, got %h", mem_name_q[0], mem_exp_q[0], mem_resp_o);
            error_cnt++;
          end
          if (!stall_seen && cycle_cnt != mem_edge_q[0])
          begin
            $display("[ERROR] %s latency: expected edge %0d, got %0d",
                     mem_name_q[0], mem_edge_q[0], cycle_cnt);
            error_cnt++;
          end
        end
      end
      // random yumi hold-off in the back-pressure phase
      mem_yumi_sent = 1'b0;
      if (mem_resp_v_o)
      begin
        if (press_mode && mem_hold == 0 && ($urandom % 2 == 0))
          mem_hold = int'($urandom % 6) + 1;
        if (mem_hold > 0)
        begin
          mem_hold--;
          stall_seen = 1'b1;
        end
        else
          mem_yumi_sent = 1'b1;
      end
      mem_resp_yumi_i = mem_yumi_sent;
    end
  end

  // I/O responses, putchar pulses and finish bits
  always @(posedge clk_i)
  begin : io_watch
    #1;
    if (!reset_i)
    begin
      if (io_yumi_sent)
      begin
        void'(io_exp_q.pop_front());
        void'(io_edge_q.pop_front());
        void'(io_name_q.pop_front());
      end
      io_yumi_sent = 1'b0;
      if (io_resp_v_o)
      begin
        check_cnt++;
        if (io_exp_q.size() == 0)
        begin
          $display("I/O response arrived with none outstanding");
          error_cnt++;
        end
        else if (io_resp_o !== io_exp_q[0] || cycle_cnt != io_edge_q[0])
        begin
          $display("[ERROR] %s: expected %h at edge %0d, got %h at edge %0d",
                   io_name_q[0], io_exp_q[0], io_edge_q[0], io_resp_o, cycle_cnt);
          error_cnt++;
        end
        io_yumi_sent = 1'b1;
      end
      io_resp_yumi_i = io_yumi_sent;
      if (putchar_v_o)
      begin
        check_cnt++;
        if (put_q.size() == 0)
        begin
          $display("putchar pulse with no putchar write pending");
          error_cnt++;
        end
        else
        begin
          if (putchar_o !== put_q[0] || cycle_cnt != put_edge_q[0])
          begin
            $display("[ERROR] %s: expected putchar %h at edge %0d, got %h at edge %0d",
                     put_name_q[0], put_q[0], put_edge_q[0], putchar_o, cycle_cnt);
            error_cnt++;
          end
          void'(put_q.pop_front());
          void'(put_edge_q.pop_front());
          void'(put_name_q.pop_front());
        end
      end
      if (fin_pending && cycle_cnt >= fin_edge)
      begin
        exp_finish = exp_finish | fin_bits;
        fin_pending = 1'b0;
      end
      check_cnt++;
      if (program_finish_o !== exp_finish)
      begin
        $display("[ERROR] program_finish: expected %b, got %b", exp_finish, program_finish_o);
        error_cnt++;
      end
    end
  end

  // ends a run that stops making progress
  initial
  begin : watchdog
    wait (load_done);
    repeat (pat_name.size() * (latency_lp + 20) + reset_cycles_lp) @(posedge clk_i);
    $display("watchdog timeout, traffic did not drain in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: verif/uncore_patterns.txt
# name port op bytes addr(hex) data(hex) expected_read_data(hex)
# port is mem or io, op is rd or wr, expected data is 0 for writes and I/O
zero_rd_a mem rd 8 00000000 0 0
zero_rd_b mem rd 4 00000104 0 0
zero_rd_c mem rd 1 000007ff 0 0
size_wr_d mem wr 8 00000040 1122334455667788 0
size_wr_b mem wr 1 00000041 ab 0
size_wr_h mem wr 2 00000046 beef 0
size_wr_w mem wr 4 00000048 deadc0de 0
size_rd_d mem rd 8 00000040 0 beef33445566ab88
size_rd_b mem rd 1 00000041 0 ab
size_rd_h mem rd 2 00000046 0 beef
size_rd_w mem rd 4 00000044 0 beef3344
size_rd_h2 mem rd 2 00000042 0 5566
size_rd_w2 mem rd 4 00000048 0 deadc0de
size_rd_b2 mem rd 1 0000004b 0 de
size_rd_b3 mem rd 1 0000004c 0 0
size_wr_lo mem wr 1 00000040 ff12 0
size_rd_lo mem rd 8 00000040 0 beef33445566ab12
pipe_wr_a mem wr 8 00000100 0123456789abcdef 0
pipe_wr_b mem wr 8 00000108 fedcba9876543210 0
pipe_rd_a mem rd 8 00000100 0 0123456789abcdef
pipe_rd_b mem rd 8 00000108 0 fedcba9876543210
pipe_rd_w mem rd 4 0000010c 0 fedcba98
pipe_rd_c mem rd 1 00000100 0 ef
press_wr_a mem wr 4 00000200 cafef00d 0
press_wr_b mem wr 4 00000204 12345678 0
press_rd_a mem rd 8 00000200 0 12345678cafef00d
press_wr_h mem wr 2 00000202 aaaa 0
press_rd_b mem rd 8 00000200 0 12345678aaaaf00d
press_rd_h mem rd 2 00000206 0 1234
press_rd_c mem rd 1 00000203 0 aa
press_rd_w mem rd 4 00000100 0 89abcdef
press_rd_d mem rd 8 00000108 0 fedcba9876543210
io_put_h io wr 1 00101000 48 0
io_put_i io wr 1 00101000 69 0
io_rd_put io rd 8 00101000 0 0
io_rd_other io rd 4 00100000 0 0
fin_core0 io wr 8 00102000 1 0
fin_core1 io wr 8 00102008 1 0
fin_core3 io wr 8 00102018 1 0
fin_rd io rd 8 00102000 0 0

// File: project.f
design/bp_uncore_msg_pkg.sv
design/bp_host_map_pkg.sv
design/bp_mem_latency.sv
design/bp_mem.sv
design/bp_nonsynth_host.sv
design/bp_uncore_top.sv
verif/testbench.sv

// File: run_sim.sh
#!/bin/sh
# build and run the uncore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module testbench -f project.f -o sim_uncore
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_uncore)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
  exit 0
fi
exit 1
